// ==== rtl/orBusPkg.sv ====
package orBusPkg;

  localparam int addressDataWidth = 32;
  localparam int burstSizeWidth = 8;
  localparam int byteEnableWidth = 4;
  localparam int resetCycles = 16;
  localparam int resetCountBits = $clog2(resetCycles) + 1;
  localparam int busTimeoutCycles = 64;

  // address map
  localparam logic [addressDataWidth-1:0] ramBaseAddress = 32'h0000_0000;
  localparam int ramWords = 1024;
  localparam int ramAddressBits = $clog2(ramWords);
  localparam int ramWindowLsb = ramAddressBits + 2;

  localparam int dmaScratchWords = 256;
  localparam int scratchIndexBits = $clog2(dmaScratchWords);
  localparam logic [7:0] dmaCustomId = 8'h12;

  // request and grant bit positions
  localparam int masterCount = 2;
  localparam int extMasterIndex = 1;
  localparam int dmaMasterIndex = 0;

  typedef struct packed {
    logic                        beginTransaction;
    logic                        endTransaction;
    logic                        readNotWrite;
    logic                        dataValid;
    logic                        busError;
    logic [byteEnableWidth-1:0]  byteEnables;
    logic [burstSizeWidth-1:0]   burstSize;
    logic [addressDataWidth-1:0] addressData;
  } busSignalsT;

  typedef struct packed {
    logic                        start;
    logic [7:0]                  n;
    logic [addressDataWidth-1:0] dataA;
    logic [addressDataWidth-1:0] dataB;
  } ciRequestT;

  typedef struct packed {
    logic                        done;
    logic [addressDataWidth-1:0] result;
  } ciResponseT;

  typedef enum logic [1:0] {arbIdle, arbGranted, arbTransaction} arbStateT;

  typedef enum logic [2:0] {
    dmaIdle, dmaRequest, dmaBegin, dmaReadBeats, dmaWriteBeats, dmaFinish
  } dmaStateT;

  typedef enum logic [1:0] {ramIdle, ramReadLatency, ramReading, ramWriting} ramStateT;

  // opcode sits in dataA[12:10]
  typedef enum logic [2:0] {
    opWriteScratch, opReadScratch, opSetBusAddress, opSetBlockSize,
    opStartRead, opStartWrite, opStatus
  } dmaOpcodeT;

endpackage

// ==== rtl/resetSequencer.sv ====
module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset
);

  logic [orBusPkg::resetCountBits-1:0] resetCount;

  // counts up once after lock and parks on the top bit
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[orBusPkg::resetCountBits-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign systemReset = ~resetCount[orBusPkg::resetCountBits-1];

endmodule

// ==== rtl/busArbiter.sv ====
module busArbiter (
  input  logic                             s_systemClock,
  input  logic                             s_pllLocked,
  input  logic                             systemReset,
  input  logic [orBusPkg::masterCount-1:0] busRequests,
  output logic [orBusPkg::masterCount-1:0] busGrants,
  input  orBusPkg::busSignalsT             busIn,
  output orBusPkg::busSignalsT             arbiterBus
);

  orBusPkg::arbStateT                            state;
  logic [orBusPkg::masterCount-1:0]              grantPick;
  logic [$clog2(orBusPkg::busTimeoutCycles)-1:0] silentCount;
  logic                                          timeoutError;

  // highest index wins
  always_comb begin
    grantPick = '0;
    for (int i = 0; i < orBusPkg::masterCount; i++) begin
      if (busRequests[i]) begin
        grantPick = '0;
        grantPick[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state        <= orBusPkg::arbIdle;
      busGrants    <= '0;
      silentCount  <= '0;
      timeoutError <= 1'b0;
    end else if (systemReset) begin
      state        <= orBusPkg::arbIdle;
      busGrants    <= '0;
      silentCount  <= '0;
      timeoutError <= 1'b0;
    end else begin
      busGrants    <= '0;
      timeoutError <= 1'b0;
      case (state)
        orBusPkg::arbIdle: begin
          silentCount <= '0;
          if (|busRequests) begin
            busGrants <= grantPick;
            state     <= orBusPkg::arbGranted;
          end
        end
        // the granted master puts out begin in the next cycle
        orBusPkg::arbGranted: state <= orBusPkg::arbTransaction;
        orBusPkg::arbTransaction: begin
          if (busIn.endTransaction || busIn.busError) begin
            state       <= orBusPkg::arbIdle;
            silentCount <= '0;
          end else if (busIn.dataValid) begin
            silentCount <= '0;
          end else begin
            silentCount  <= silentCount + 1'b1;
            timeoutError <= (silentCount == orBusPkg::busTimeoutCycles - 1);
          end
        end
        default: state <= orBusPkg::arbIdle;
      endcase
    end
  end

  // a timeout closes the transaction as well
  always_comb begin
    arbiterBus = '0;
    arbiterBus.busError = timeoutError;
    arbiterBus.endTransaction = timeoutError;
  end

endmodule

// ==== rtl/ramSlave.sv ====
module ramSlave (
  input  logic                 s_systemClock,
  input  logic                 s_pllLocked,
  input  logic                 systemReset,
  input  orBusPkg::busSignalsT busIn,
  output orBusPkg::busSignalsT slaveBus
);

  logic [orBusPkg::addressDataWidth-1:0] memory [orBusPkg::ramWords];

  orBusPkg::ramStateT                    state;
  logic [orBusPkg::ramAddressBits-1:0]   wordAddress;
  logic [orBusPkg::burstSizeWidth-1:0]   beatsLeft;
  logic [orBusPkg::byteEnableWidth-1:0]  byteEnables;
  logic [orBusPkg::addressDataWidth-1:0] readWord;
  logic                                  inWindow;
  logic                                  beatValid;
  logic                                  beatEnd;

  assign inWindow = busIn.addressData[orBusPkg::addressDataWidth-1:orBusPkg::ramWindowLsb] ==
                    orBusPkg::ramBaseAddress[orBusPkg::addressDataWidth-1:orBusPkg::ramWindowLsb];

  always_ff @(posedge s_systemClock) begin
    if (state == orBusPkg::ramWriting && busIn.dataValid) begin
      for (int b = 0; b < orBusPkg::byteEnableWidth; b++) begin
        if (byteEnables[b]) begin
          memory[wordAddress][8*b +: 8] <= busIn.addressData[8*b +: 8];
        end
      end
    end
    readWord <= memory[wordAddress];
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state     <= orBusPkg::ramIdle;
      beatValid <= 1'b0;
      beatEnd   <= 1'b0;
    end else if (systemReset) begin
      state     <= orBusPkg::ramIdle;
      beatValid <= 1'b0;
      beatEnd   <= 1'b0;
    end else begin
      beatEnd <= 1'b0;
      case (state)
        orBusPkg::ramIdle: begin
          if (busIn.beginTransaction && inWindow) begin
            wordAddress <= busIn.addressData[orBusPkg::ramWindowLsb-1:2];
            beatsLeft   <= busIn.burstSize;
            byteEnables <= busIn.byteEnables;
            state       <= busIn.readNotWrite ? orBusPkg::ramReadLatency : orBusPkg::ramWriting;
          end
        end
        // readWord picks up the first word on this edge
        orBusPkg::ramReadLatency: begin
          beatValid   <= 1'b1;
          wordAddress <= wordAddress + 1'b1;
          state       <= orBusPkg::ramReading;
        end
        orBusPkg::ramReading: begin
          if (busIn.busError) begin
            beatValid <= 1'b0;
            state     <= orBusPkg::ramIdle;
          end else if (beatsLeft == '0) begin
            beatValid <= 1'b0;
            beatEnd   <= 1'b1;
            state     <= orBusPkg::ramIdle;
          end else begin
            beatsLeft   <= beatsLeft - 1'b1;
            wordAddress <= wordAddress + 1'b1;
          end
        end
        orBusPkg::ramWriting: begin
          if (busIn.dataValid) begin
            wordAddress <= wordAddress + 1'b1;
          end
          if (busIn.endTransaction || busIn.busError) begin
            state <= orBusPkg::ramIdle;
          end
        end
        default: state <= orBusPkg::ramIdle;
      endcase
    end
  end

  always_comb begin
    slaveBus = '0;
    slaveBus.dataValid = beatValid;
    slaveBus.endTransaction = beatEnd;
    if (beatValid) begin
      slaveBus.addressData = readWord;
    end
  end

endmodule

// ==== rtl/dmaEngine.sv ====
module dmaEngine (
  input  logic                 s_systemClock,
  input  logic                 s_pllLocked,
  input  logic                 systemReset,
  input  orBusPkg::ciRequestT  ciRequest,
  output orBusPkg::ciResponseT ciResponse,
  output logic                 busRequest,
  input  logic                 busGrant,
  input  orBusPkg::busSignalsT busIn,
  output orBusPkg::busSignalsT dmaBus
);

  logic [orBusPkg::addressDataWidth-1:0] scratch [orBusPkg::dmaScratchWords];

  orBusPkg::dmaStateT                    state;
  orBusPkg::dmaOpcodeT                   opcode;
  orBusPkg::busSignalsT                  busOut;
  logic                                  ciSelected;
  logic                                  busy;
  logic                                  startTransfer;
  logic [orBusPkg::scratchIndexBits-1:0] ciIndex;
  logic [orBusPkg::scratchIndexBits-1:0] scratchIndex;
  logic [orBusPkg::scratchIndexBits-1:0] scratchWriteIndex;
  logic [orBusPkg::addressDataWidth-1:0] scratchWriteData;
  logic                                  scratchWrite;
  logic [orBusPkg::addressDataWidth-1:0] ciReadWord;
  logic [orBusPkg::addressDataWidth-1:0] beatWord;
  logic [orBusPkg::addressDataWidth-1:0] busAddress;
  logic [orBusPkg::burstSizeWidth-1:0]   blockBurst;
  logic [orBusPkg::burstSizeWidth-1:0]   beatsLeft;
  logic                                  readNotWrite;
  logic                                  transferError;
  logic                                  ciDone;
  logic                                  respIsRead;
  logic [1:0]                            statusBits;

  assign ciSelected = ciRequest.start && (ciRequest.n == orBusPkg::dmaCustomId);
  assign opcode = orBusPkg::dmaOpcodeT'(ciRequest.dataA[12:10]);
  assign ciIndex = ciRequest.dataA[orBusPkg::scratchIndexBits-1:0];
  assign busy = (state != orBusPkg::dmaIdle);
  assign startTransfer = ciSelected && !busy &&
                         (opcode == orBusPkg::opStartRead || opcode == orBusPkg::opStartWrite);

  // incoming bus beats win over a CI write in the same cycle
  always_comb begin
    scratchWrite = 1'b0;
    scratchWriteIndex = ciIndex;
    scratchWriteData = ciRequest.dataB;
    if (state == orBusPkg::dmaReadBeats && busIn.dataValid) begin
      scratchWrite = 1'b1;
      scratchWriteIndex = scratchIndex;
      scratchWriteData = busIn.addressData;
    end else if (ciSelected && opcode == orBusPkg::opWriteScratch) begin
      scratchWrite = 1'b1;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (scratchWrite) begin
      scratch[scratchWriteIndex] <= scratchWriteData;
    end
    ciReadWord <= scratch[ciIndex];
    beatWord   <= scratch[scratchIndex];
  end

  // transfer setup, held while a transfer runs
  always_ff @(posedge s_systemClock) begin
    if (ciSelected && !busy) begin
      if (opcode == orBusPkg::opSetBusAddress) begin
        busAddress <= ciRequest.dataB;
      end
      if (opcode == orBusPkg::opSetBlockSize) begin
        blockBurst <= ciRequest.dataB[orBusPkg::burstSizeWidth-1:0] - 1'b1;
      end
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciDone     <= 1'b0;
      respIsRead <= 1'b0;
      statusBits <= '0;
    end else if (systemReset) begin
      ciDone     <= 1'b0;
      respIsRead <= 1'b0;
      statusBits <= '0;
    end else begin
      ciDone     <= ciSelected;
      respIsRead <= ciSelected && (opcode == orBusPkg::opReadScratch);
      statusBits <= (ciSelected && opcode == orBusPkg::opStatus) ? {transferError, busy} : 2'b00;
    end
  end

  always_comb begin
    ciResponse.done = ciDone;
    ciResponse.result = respIsRead ? ciReadWord : {30'd0, statusBits};
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state         <= orBusPkg::dmaIdle;
      busRequest    <= 1'b0;
      busOut        <= '0;
      scratchIndex  <= '0;
      beatsLeft     <= '0;
      readNotWrite  <= 1'b0;
      transferError <= 1'b0;
    end else if (systemReset) begin
      state         <= orBusPkg::dmaIdle;
      busRequest    <= 1'b0;
      busOut        <= '0;
      scratchIndex  <= '0;
      beatsLeft     <= '0;
      readNotWrite  <= 1'b0;
      transferError <= 1'b0;
    end else begin
      case (state)
        orBusPkg::dmaIdle: begin
          if (startTransfer) begin
            busRequest    <= 1'b1;
            readNotWrite  <= (opcode == orBusPkg::opStartRead);
            transferError <= 1'b0;
            scratchIndex  <= '0;
            beatsLeft     <= blockBurst;
            state         <= orBusPkg::dmaRequest;
          end
        end
        orBusPkg::dmaRequest: begin
          if (busGrant) begin
            busRequest              <= 1'b0;
            busOut.beginTransaction <= 1'b1;
            busOut.readNotWrite     <= readNotWrite;
            busOut.burstSize        <= blockBurst;
            busOut.byteEnables      <= '1;
            busOut.addressData      <= busAddress;
            state                   <= orBusPkg::dmaBegin;
          end
        end
        orBusPkg::dmaBegin: begin
          busOut <= '0;
          if (readNotWrite) begin
            state <= orBusPkg::dmaReadBeats;
          end else begin
            // beatWord holds scratch[0] from this edge on
            busOut.dataValid <= 1'b1;
            scratchIndex     <= scratchIndex + 1'b1;
            state            <= orBusPkg::dmaWriteBeats;
          end
        end
        orBusPkg::dmaWriteBeats: begin
          if (busIn.busError) begin
            busOut        <= '0;
            transferError <= 1'b1;
            state         <= orBusPkg::dmaFinish;
          end else if (beatsLeft == '0) begin
            busOut.dataValid      <= 1'b0;
            busOut.endTransaction <= 1'b1;
            state                 <= orBusPkg::dmaFinish;
          end else begin
            beatsLeft    <= beatsLeft - 1'b1;
            scratchIndex <= scratchIndex + 1'b1;
          end
        end
        orBusPkg::dmaReadBeats: begin
          if (busIn.dataValid) begin
            scratchIndex <= scratchIndex + 1'b1;
          end
          if (busIn.busError) begin
            transferError <= 1'b1;
          end
          if (busIn.endTransaction || busIn.busError) begin
            state <= orBusPkg::dmaFinish;
          end
        end
        orBusPkg::dmaFinish: begin
          busOut <= '0;
          state  <= orBusPkg::dmaIdle;
        end
        default: state <= orBusPkg::dmaIdle;
      endcase
    end
  end

  always_comb begin
    dmaBus = busOut;
    if (busOut.dataValid) begin
      dmaBus.addressData = beatWord;
    end
  end

endmodule

// ==== rtl/orBusSystem.sv ====
module orBusSystem (
  input  logic                 s_systemClock,
  input  logic                 s_pllLocked,
  output logic                 resetDone,
  input  orBusPkg::ciRequestT  ciRequest,
  output orBusPkg::ciResponseT ciResponse,
  input  logic                 extRequest,
  output logic                 extGrant,
  input  orBusPkg::busSignalsT extBus,
  output orBusPkg::busSignalsT busIn
);

  logic                             systemReset;
  logic                             dmaRequest;
  logic [orBusPkg::masterCount-1:0] busRequests;
  logic [orBusPkg::masterCount-1:0] busGrants;
  orBusPkg::busSignalsT             arbiterBus;
  orBusPkg::busSignalsT             slaveBus;
  orBusPkg::busSignalsT             dmaBus;

  resetSequencer u_resetSequencer (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReset   (systemReset)
  );

  assign resetDone = ~systemReset;

  assign busRequests[orBusPkg::extMasterIndex] = extRequest;
  assign busRequests[orBusPkg::dmaMasterIndex] = dmaRequest;
  assign extGrant = busGrants[orBusPkg::extMasterIndex];

  busArbiter u_busArbiter (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReset   (systemReset),
    .busRequests   (busRequests),
    .busGrants     (busGrants),
    .busIn         (busIn),
    .arbiterBus    (arbiterBus)
  );

  ramSlave u_ramSlave (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReset   (systemReset),
    .busIn         (busIn),
    .slaveBus      (slaveBus)
  );

  dmaEngine u_dmaEngine (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReset   (systemReset),
    .ciRequest     (ciRequest),
    .ciResponse    (ciResponse),
    .busRequest    (dmaRequest),
    .busGrant      (busGrants[orBusPkg::dmaMasterIndex]),
    .busIn         (busIn),
    .dmaBus        (dmaBus)
  );

  // wired-OR bus, idle peers drive zeros
  assign busIn = orBusPkg::busSignalsT'(extBus | arbiterBus | slaveBus | dmaBus);

endmodule

// ==== tb/orBusSystemSva.sv ====
module orBusSystemSva (
  input logic                             s_systemClock,
  input logic                             s_pllLocked,
  input logic                             systemReset,
  input logic [orBusPkg::masterCount-1:0] busGrants,
  input orBusPkg::busSignalsT             busIn,
  input orBusPkg::arbStateT               state
);

  int failureCount = 0;

  grantOneHot: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked || systemReset)
    $onehot0(busGrants)
  ) else begin
    $error("more than one bus grant at a time");
    failureCount++;
  end

  // the grant register is loaded only while idle
  grantFromIdle: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked || systemReset)
    |busGrants |-> $past(state) == orBusPkg::arbIdle
  ) else begin
    $error("bus grant issued outside the idle state");
    failureCount++;
  end

  beginAfterGrant: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked || systemReset)
    |busGrants |=> busIn.beginTransaction
  ) else begin
    $error("no beginTransaction in the cycle after a grant");
    failureCount++;
  end

  errorEndsTransaction: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked || systemReset)
    busIn.busError |-> busIn.endTransaction
  ) else begin
    $error("busError without endTransaction");
    failureCount++;
  end

endmodule

bind busArbiter orBusSystemSva u_orBusSystemSva (
  .s_systemClock (s_systemClock),
  .s_pllLocked   (s_pllLocked),
  .systemReset   (systemReset),
  .busGrants     (busGrants),
  .busIn         (busIn),
  .state         (state)
);

// ==== tb/orBusSystemTb.sv ====
module orBusSystemTb;

  localparam int resetHoldCycles = 16;
  localparam int burstBase = 16;
  localparam int burstWords = 32;
  localparam int dmaWriteBase = 256;
  localparam int dmaWords = 16;
  localparam int dmaReadWords = 24;
  localparam int arbitrationBase = 512;
  localparam logic [31:0] unmappedAddress = 32'h8000_0000;
  localparam int transferSlack = 16;
  localparam int grantWaitLimit = 2 * orBusPkg::busTimeoutCycles + 4 * transferSlack;
  localparam int beatWaitLimit = orBusPkg::busTimeoutCycles + transferSlack;
  localparam int statusPollLimit = orBusPkg::dmaScratchWords + orBusPkg::busTimeoutCycles;

  // worst case of each test in cycles, doubled for margin
  localparam int resetBudget = resetHoldCycles + orBusPkg::resetCycles + 4;
  localparam int burstBudget = 4 * (burstWords + transferSlack);
  localparam int dmaBudget = 4 * (dmaWords + dmaReadWords) + 6 * transferSlack + 20;
  localparam int unmappedBudget = 2 * (orBusPkg::busTimeoutCycles + transferSlack) + 20;
  localparam int arbitrationBudget = 4 * (dmaWords + transferSlack);
  localparam int watchdogCycles =
    2 * (resetBudget + burstBudget + dmaBudget + unmappedBudget + arbitrationBudget);

  logic                 s_systemClock;
  logic                 s_pllLocked;
  logic                 resetDone;
  logic                 extRequest;
  logic                 extGrant;
  orBusPkg::ciRequestT  ciRequest;
  orBusPkg::ciResponseT ciResponse;
  orBusPkg::busSignalsT extBus;
  orBusPkg::busSignalsT busIn;

  logic [31:0] ramModel [orBusPkg::ramWords];
  logic [31:0] scratchModel [orBusPkg::dmaScratchWords];
  logic [31:0] lfsrState = 32'hf1bb;

  orBusSystem u_orBusSystem (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .resetDone     (resetDone),
    .ciRequest     (ciRequest),
    .ciResponse    (ciResponse),
    .extRequest    (extRequest),
    .extGrant      (extGrant),
    .extBus        (extBus),
    .busIn         (busIn)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #2 s_systemClock = ~s_systemClock;
  end

  initial begin
    repeat (watchdogCycles) @(posedge s_systemClock);
    reportFailure($sformatf("watchdog expired after %0d cycles", watchdogCycles));
  end

  // galois lfsr, one step per output bit
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < count; i++) begin
      outBit = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) begin
        lfsrState = lfsrState ^ 32'h8020_0003;
      end
      value = {value[30:0], outBit};
    end
    return value;
  endfunction

  task automatic reportFailure(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      reportFailure($sformatf("MISMATCH %s expected %h actual %h", testName, expected, actual));
    end
  endtask

  task automatic checkTrue(input logic condition, input string reason);
    assert (condition === 1'b1) else begin
      reportFailure(reason);
    end
  endtask

  function automatic orBusPkg::ciRequestT makeCiRequest(input logic [7:0] n,
      input orBusPkg::dmaOpcodeT opcode, input logic [7:0] index, input logic [31:0] dataB);
    orBusPkg::ciRequestT request;
    request = '0;
    request.start = 1'b1;
    request.n = n;
    request.dataA[12:10] = opcode;
    request.dataA[7:0] = index;
    request.dataB = dataB;
    return request;
  endfunction

  // every task starts and returns right after a falling edge
  task automatic dmaCommand(input string testName, input orBusPkg::dmaOpcodeT opcode,
      input logic [7:0] index, input logic [31:0] dataB, output logic [31:0] result);
    ciRequest = makeCiRequest(orBusPkg::dmaCustomId, opcode, index, dataB);
    @(negedge s_systemClock);
    checkValue({testName, " done"}, 32'd1, ciResponse.done);
    result = ciResponse.result;
    ciRequest = '0;
  endtask

  task automatic waitDmaIdle(input string testName, output logic [31:0] status);
    int          polls;
    logic [31:0] result;
    polls = 0;
    do begin
      dmaCommand({testName, " status"}, orBusPkg::opStatus, 8'd0, 32'd0, result);
      polls++;
      checkTrue(polls <= statusPollLimit, {testName, ": DMA stayed busy too long"});
    end while (result[0]);
    status = result;
  endtask

  task automatic acquireBus(input string testName);
    int waited;
    extRequest = 1'b1;
    waited = 0;
    do begin
      @(negedge s_systemClock);
      waited++;
      checkTrue(waited <= grantWaitLimit, {testName, ": external port never got the bus"});
    end while (!extGrant);
    // begin goes out in the cycle after the grant
    @(negedge s_systemClock);
    extRequest = 1'b0;
  endtask

  task automatic beginRead(input logic [31:0] byteAddress, input int count);
    extBus = '0;
    extBus.beginTransaction = 1'b1;
    extBus.readNotWrite = 1'b1;
    extBus.byteEnables = '1;
    extBus.burstSize = count - 1;
    extBus.addressData = byteAddress;
  endtask

  task automatic collectRead(input string testName, input int wordIndex, input int count);
    orBusPkg::busSignalsT sampled;
    int                   beats;
    int                   waited;
    logic                 lastValid;
    logic                 finished;
    beats = 0;
    waited = 0;
    lastValid = 1'b0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge s_systemClock);
      sampled = busIn;
      extBus = '0;
      waited++;
      checkTrue(waited <= count + beatWaitLimit, {testName, ": read burst never ended"});
      checkTrue(!sampled.busError, {testName, ": unexpected bus error"});
      if (sampled.endTransaction) begin
        checkValue({testName, " beat count"}, count, beats);
        checkTrue(lastValid, {testName, ": end did not follow the last beat"});
        finished = 1'b1;
      end else begin
        lastValid = sampled.dataValid;
        if (sampled.dataValid) begin
          checkTrue(beats < count, {testName, ": more beats than requested"});
          checkValue($sformatf("%s word %0d", testName, wordIndex + beats),
                     ramModel[wordIndex + beats], sampled.addressData);
          beats++;
        end
      end
    end
  endtask

  task automatic readBurst(input string testName, input int wordIndex, input int count);
    acquireBus(testName);
    beginRead(orBusPkg::ramBaseAddress + 4 * wordIndex, count);
    collectRead(testName, wordIndex, count);
  endtask

  task automatic writeBurst(input string testName, input int wordIndex, input int count,
                            input logic [3:0] enables);
    logic [31:0] word;
    acquireBus(testName);
    extBus = '0;
    extBus.beginTransaction = 1'b1;
    extBus.byteEnables = enables;
    extBus.burstSize = count - 1;
    extBus.addressData = orBusPkg::ramBaseAddress + 4 * wordIndex;
    for (int beat = 0; beat < count; beat++) begin
      @(negedge s_systemClock);
      word = randomBits(32);
      extBus = '0;
      extBus.dataValid = 1'b1;
      extBus.addressData = word;
      for (int b = 0; b < 4; b++) begin
        if (enables[b]) begin
          ramModel[wordIndex + beat][8*b +: 8] = word[8*b +: 8];
        end
      end
    end
    @(negedge s_systemClock);
    extBus = '0;
    extBus.endTransaction = 1'b1;
    @(negedge s_systemClock);
    extBus = '0;
  endtask

  task automatic resetRelease();
    repeat (resetHoldCycles) @(negedge s_systemClock);
    // requests held through reset must stay unanswered
    extRequest = 1'b1;
    ciRequest = makeCiRequest(orBusPkg::dmaCustomId, orBusPkg::opStatus, 8'd0, 32'd0);
    s_pllLocked = 1'b1;
    for (int edgeCount = 1; edgeCount <= orBusPkg::resetCycles; edgeCount++) begin
      @(negedge s_systemClock);
      checkValue($sformatf("reset resetDone edge %0d", edgeCount),
                 edgeCount == orBusPkg::resetCycles, resetDone);
      checkValue($sformatf("reset extGrant edge %0d", edgeCount), 32'd0, extGrant);
      checkValue($sformatf("reset ci done edge %0d", edgeCount), 32'd0, ciResponse.done);
    end
    extRequest = 1'b0;
    ciRequest = '0;
  endtask

  task automatic burstWriteRead();
    logic [3:0] enables;
    writeBurst("burst write", burstBase, burstWords, 4'hf);
    for (int part = 0; part < 2; part++) begin
      enables = randomBits(4);
      if (enables == 4'h0 || enables == 4'hf) begin
        enables = 4'b0110;
      end
      writeBurst($sformatf("burst partial write %0d", part), burstBase + 4 + 16 * part, 8,
                 enables);
    end
    readBurst("burst read", burstBase, burstWords);
  endtask

  task automatic dmaTransfers();
    logic [31:0] result;
    logic [31:0] word;
    for (int i = 0; i < dmaWords; i++) begin
      word = randomBits(32);
      scratchModel[i] = word;
      dmaCommand("dma fill", orBusPkg::opWriteScratch, i[7:0], word, result);
    end
    dmaCommand("dma address", orBusPkg::opSetBusAddress, 8'd0, 4 * dmaWriteBase, result);
    dmaCommand("dma size", orBusPkg::opSetBlockSize, 8'd0, dmaWords, result);
    dmaCommand("dma start write", orBusPkg::opStartWrite, 8'd0, 32'd0, result);
    waitDmaIdle("dma write", result);
    checkValue("dma write status", 32'd0, result[1:0]);
    for (int i = 0; i < dmaWords; i++) begin
      ramModel[dmaWriteBase + i] = scratchModel[i];
    end
    readBurst("dma write readback", dmaWriteBase, dmaWords);

    dmaCommand("dma address", orBusPkg::opSetBusAddress, 8'd0, 4 * burstBase, result);
    dmaCommand("dma size", orBusPkg::opSetBlockSize, 8'd0, dmaReadWords, result);
    dmaCommand("dma start read", orBusPkg::opStartRead, 8'd0, 32'd0, result);
    waitDmaIdle("dma read", result);
    checkValue("dma read status", 32'd0, result[1:0]);
    for (int i = 0; i < dmaReadWords; i++) begin
      scratchModel[i] = ramModel[burstBase + i];
      dmaCommand("dma read scratch", orBusPkg::opReadScratch, i[7:0], 32'd0, result);
      checkValue($sformatf("dma scratch word %0d", i), scratchModel[i], result);
    end

    // another instruction number must not be answered
    ciRequest = makeCiRequest(orBusPkg::dmaCustomId + 8'd1, orBusPkg::opStatus, 8'd0, 32'd0);
    for (int i = 0; i < 4; i++) begin
      @(negedge s_systemClock);
      ciRequest = '0;
      checkValue($sformatf("foreign ci done cycle %0d", i + 1), 32'd0, ciResponse.done);
    end
  endtask

  task automatic unmappedAccess();
    orBusPkg::busSignalsT sampled;
    logic [31:0]          result;
    int                   waited;
    acquireBus("unmapped read");
    beginRead(unmappedAddress, 4);
    waited = 0;
    do begin
      @(negedge s_systemClock);
      sampled = busIn;
      extBus = '0;
      waited++;
      checkTrue(waited <= beatWaitLimit, "unmapped read: no bus error arrived");
      checkTrue(!sampled.dataValid, "unmapped read: a slave answered");
    end while (!sampled.busError);
    checkTrue(sampled.endTransaction, "unmapped read: bus error without end");

    dmaCommand("dma unmapped address", orBusPkg::opSetBusAddress, 8'd0, unmappedAddress,
               result);
    dmaCommand("dma unmapped size", orBusPkg::opSetBlockSize, 8'd0, 32'd4, result);
    dmaCommand("dma unmapped start", orBusPkg::opStartRead, 8'd0, 32'd0, result);
    waitDmaIdle("dma unmapped", result);
    checkValue("dma unmapped status", 32'd2, result[1:0]);
  endtask

  task automatic arbitrationOrder();
    logic [31:0] result;
    int          waited;
    logic        sawDmaEnd;
    dmaCommand("arb address", orBusPkg::opSetBusAddress, 8'd0, 4 * arbitrationBase, result);
    dmaCommand("arb size", orBusPkg::opSetBlockSize, 8'd0, dmaWords, result);
    dmaCommand("arb start write", orBusPkg::opStartWrite, 8'd0, 32'd0, result);
    for (int i = 0; i < dmaWords; i++) begin
      ramModel[arbitrationBase + i] = scratchModel[i];
    end
    waited = 0;
    do begin
      @(negedge s_systemClock);
      waited++;
      checkTrue(waited <= grantWaitLimit, "arbitration: DMA never began its transfer");
    end while (!busIn.beginTransaction);

    extRequest = 1'b1;
    sawDmaEnd = 1'b0;
    waited = 0;
    do begin
      @(negedge s_systemClock);
      waited++;
      checkTrue(waited <= grantWaitLimit, "arbitration: external port never got the bus");
      if (busIn.endTransaction) begin
        sawDmaEnd = 1'b1;
      end
    end while (!extGrant);
    checkTrue(sawDmaEnd, "arbitration: external grant came before the DMA end");
    @(negedge s_systemClock);
    extRequest = 1'b0;
    beginRead(orBusPkg::ramBaseAddress + 4 * arbitrationBase, dmaWords);
    collectRead("arbitration read", arbitrationBase, dmaWords);
    waitDmaIdle("arbitration dma", result);
    checkValue("arbitration dma status", 32'd0, result[1:0]);
  endtask

  initial begin
    s_pllLocked = 1'b0;
    extRequest = 1'b0;
    ciRequest = '0;
    extBus = '0;
    resetRelease();
    burstWriteRead();
    dmaTransfers();
    unmappedAccess();
    arbitrationOrder();
    if (u_orBusSystem.u_busArbiter.u_orBusSystemSva.failureCount != 0) begin
      reportFailure("a bus protocol assertion failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== src.f ====
rtl/orBusPkg.sv
rtl/resetSequencer.sv
rtl/busArbiter.sv
rtl/ramSlave.sv
rtl/dmaEngine.sv
rtl/orBusSystem.sv
tb/orBusSystemSva.sv
tb/orBusSystemTb.sv
